// File: bench/mem_bit_checker.sv
`timescale 1ns/10ps

module mem_bit_checker #(
  parameter int NUMADDR    = 1024,
  parameter int SRAM_DELAY = 1,
  parameter int FLOPIN     = 0,
  parameter int FLOPOUT    = 0
) (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic [mem_pkg::BITADDR-1:0]                    select_addr,
  input  logic [$clog2(mem_pkg::WIDTH)-1:0]              select_bit,
  // SRAM port A, then B, C, D
  input  mem_pkg::wr_req_t                               sram_wr,
  input  mem_pkg::rd_req_t [mem_pkg::NUM_RD-1:0]         sram_rd,
  input  logic [mem_pkg::NUM_RD-1:0][mem_pkg::WIDTH-1:0] sram_dout,
  // User side of mem_3r1w
  input  mem_pkg::wr_req_t                               wr,
  input  mem_pkg::rd_req_t [mem_pkg::NUM_RD-1:0]         rd,
  input  mem_pkg::rd_rsp_t [mem_pkg::NUM_RD-1:0]         rsp,
  output logic                                           err
);

  import mem_pkg::*;

  localparam int LATENCY = FLOPIN + SRAM_DELAY + FLOPOUT;

  // Shadow bits, known once written
  logic sram_bit   = 1'b0;
  logic sram_known = 1'b0;
  logic user_bit   = 1'b0;
  logic user_known = 1'b0;
  logic sram_err   = 1'b0;
  logic user_err   = 1'b0;

  // Stage s holds reads issued s cycles ago
  logic [NUM_RD-1:0] sram_hit [SRAM_DELAY+1] = '{default: '0};
  logic [NUM_RD-1:0] sram_exp [SRAM_DELAY+1] = '{default: '0};
  logic [NUM_RD-1:0] user_hit [LATENCY+1]    = '{default: '0};
  logic [NUM_RD-1:0] user_exp [LATENCY+1]    = '{default: '0};

  assign err = sram_err | user_err;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // SRAM level shadow
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    for (int s = SRAM_DELAY; s > 0; s--) begin
      sram_hit[s] = sram_hit[s-1];
      sram_exp[s] = sram_exp[s-1];
    end
    for (int p = 0; p < NUM_RD; p++) begin
      sram_hit[0][p] = sram_known && sram_rd[p].read && (sram_rd[p].adr == select_addr);
      sram_exp[0][p] = sram_bit;
      if (sram_hit[SRAM_DELAY][p]) begin
        assert (sram_dout[p][select_bit] == sram_exp[SRAM_DELAY][p]) else begin
          $display("[ERROR] u_sram.dout[%0d][%0d] = %h, expected %h",
                   p, select_bit, sram_dout[p][select_bit], sram_exp[SRAM_DELAY][p]);
          sram_err = 1'b1;
        end
      end
    end
    // Port A lands after B, C, D took the old bit
    if (sram_wr.write && (sram_wr.adr == select_addr) && sram_wr.bw[select_bit]) begin
      sram_bit   = sram_wr.din[select_bit];
      sram_known = 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // User level shadow
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    for (int s = LATENCY; s > 0; s--) begin
      user_hit[s] = user_hit[s-1];
      user_exp[s] = user_exp[s-1];
    end
    for (int p = 0; p < NUM_RD; p++) begin
      user_hit[0][p] = user_known && rd[p].read && (int'(rd[p].adr) < NUMADDR) &&
                       (rd[p].adr == select_addr);
      user_exp[0][p] = user_bit;
    end
    if (rst) begin
      for (int s = 0; s <= LATENCY; s++) begin
        user_hit[s] = '0;
      end
    end
    for (int p = 0; p < NUM_RD; p++) begin
      if (user_hit[LATENCY][p]) begin
        assert (rsp[p].vld && (rsp[p].dout[select_bit] == user_exp[LATENCY][p])) else begin
          $display("[ERROR] rsp[%0d].vld = %h rsp[%0d].dout[%0d] = %h, expected 1 and %h",
                   p, rsp[p].vld, p, select_bit, rsp[p].dout[select_bit],
                   user_exp[LATENCY][p]);
          user_err = 1'b1;
        end
      end
    end
    if (!rst && wr.write && (int'(wr.adr) < NUMADDR) && (wr.adr == select_addr) &&
        wr.bw[select_bit]) begin
      user_bit   = wr.din[select_bit];
      user_known = 1'b1;
    end
  end

endmodule

// File: bench/tb_mem_3r1w.sv
`timescale 1ns/10ps

module tb_mem_3r1w;

  import mem_pkg::*;

  localparam int NUMADDR     = 768;
  localparam int SRAM_DELAY  = 1;
  localparam int FLOPIN      = 1;
  localparam int FLOPOUT     = 1;
  localparam int LATENCY     = FLOPIN + SRAM_DELAY + FLOPOUT;
  localparam int CLK_PERIOD  = 8;
  localparam int RAND_CYCLES = 2000;
  localparam int TEST_CYCLES = 3 + 5 + NUMADDR + 10 + NUMADDR / NUM_RD + RAND_CYCLES + 20;
  localparam int WDOG_CYCLES = TEST_CYCLES + 200;

  typedef rd_req_t [NUM_RD-1:0] rd_vec_t;

  typedef struct packed {
    logic [31:0]      due;
    logic [1:0]       port;
    logic [WIDTH-1:0] data;
  } exp_t;

  logic               clk = 1'b0;
  logic               rst;
  wr_req_t            wr;
  rd_vec_t            rd;
  rd_rsp_t [NUM_RD-1:0] rsp;
  logic               bit_err;
  logic [31:0]        cyc = '0;
  integer             seed = 70;
  logic [BITADDR-1:0] select_addr;
  logic [3:0]         select_bit;
  logic [WIDTH-1:0]   ref_mem [NUMADDR];
  exp_t               exp_q [$];

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  mem_3r1w #(
    .NUMADDR    (NUMADDR),
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPIN     (FLOPIN),
    .FLOPOUT    (FLOPOUT)
  ) u_dut (
    .clk (clk),
    .rst (rst),
    .wr  (wr),
    .rd  (rd),
    .rsp (rsp)
  );

  mem_bit_checker #(
    .NUMADDR    (NUMADDR),
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPIN     (FLOPIN),
    .FLOPOUT    (FLOPOUT)
  ) u_bit_chk (
    .clk         (clk),
    .rst         (rst),
    .select_addr (select_addr),
    .select_bit  (select_bit),
    .sram_wr     (u_dut.u_sram.wr),
    .sram_rd     (u_dut.u_sram.rd),
    .sram_dout   (u_dut.u_sram.dout),
    .wr          (wr),
    .rd          (rd),
    .rsp         (rsp),
    .err         (bit_err)
  );

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at first error");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Word a read sees before the same cycle's write
  function automatic logic [WIDTH-1:0] expected_word(input logic [BITADDR-1:0] adr);
    return ref_mem[adr];
  endfunction

  function automatic logic [WIDTH-1:0] masked_merge(input logic [WIDTH-1:0] old_word,
                                                     input logic [WIDTH-1:0] din,
                                                     input logic [WIDTH-1:0] bw);
    logic [WIDTH-1:0] word;
    word = old_word;
    for (int i = 0; i < WIDTH; i++) begin
      if (bw[i]) begin
        word[i] = din[i];
      end
    end
    return word;
  endfunction

  function automatic logic [WIDTH-1:0] fill_word(input logic [BITADDR-1:0] adr);
    return {adr[5:0], adr} ^ 16'h5A3C;
  endfunction

  function automatic wr_req_t make_write(input logic en, input logic [BITADDR-1:0] adr,
                                         input logic [WIDTH-1:0] din,
                                         input logic [WIDTH-1:0] bw);
    wr_req_t w;
    w.write = en;
    w.adr   = adr;
    w.din   = din;
    w.bw    = bw;
    return w;
  endfunction

  function automatic rd_vec_t read_all(input logic [BITADDR-1:0] adr);
    rd_vec_t r;
    for (int p = 0; p < NUM_RD; p++) begin
      r[p].read = 1'b1;
      r[p].adr  = adr;
    end
    return r;
  endfunction

  // Selected address one time in four
  function automatic logic [BITADDR-1:0] random_addr();
    if (($random(seed) & 3) == 0) begin
      return select_addr;
    end
    return BITADDR'($random(seed));
  endfunction

  // Drive one cycle and queue the responses it should produce
  task automatic drive_cycle(input wr_req_t w, input rd_vec_t r);
    exp_t e;
    @(negedge clk);
    for (int p = 0; p < NUM_RD; p++) begin
      if (r[p].read && (int'(r[p].adr) < NUMADDR)) begin
        e.due  = cyc + LATENCY;
        e.port = 2'(p);
        e.data = expected_word(r[p].adr);
        exp_q.push_back(e);
      end
    end
    if (w.write && (int'(w.adr) < NUMADDR)) begin
      ref_mem[w.adr] = masked_merge(ref_mem[w.adr], w.din, w.bw);
    end
    wr = w;
    rd = r;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin
    logic [NUM_RD-1:0]            due_vld;
    logic [NUM_RD-1:0][WIDTH-1:0] due_data;
    due_vld  = '0;
    due_data = '0;
    while (exp_q.size() > 0 && exp_q[0].due == cyc) begin
      due_vld[exp_q[0].port]  = 1'b1;
      due_data[exp_q[0].port] = exp_q[0].data;
      void'(exp_q.pop_front());
    end
    if (!rst) begin
      for (int p = 0; p < NUM_RD; p++) begin
        assert (rsp[p].vld == due_vld[p]) else begin
          $display("[ERROR] rsp[%0d].vld = %h, expected %h (cycle %0d)",
                   p, rsp[p].vld, due_vld[p], cyc);
          stop_with_failure();
        end
        // Idle ports must show zero data
        assert (rsp[p].dout == due_data[p]) else begin
          $display("[ERROR] rsp[%0d].dout = %h, expected %h (cycle %0d)",
                   p, rsp[p].dout, due_data[p], cyc);
          stop_with_failure();
        end
      end
    end
  end

  always @(posedge bit_err) begin
    $display("Selected bit checker found a mismatch");
    stop_with_failure();
  end

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WDOG_CYCLES);
    stop_with_failure();
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    wr_req_t w;
    rd_vec_t r;
    rst         = 1'b1;
    wr          = '0;
    rd          = '0;
    select_addr = BITADDR'($unsigned($random(seed)) % NUMADDR);
    select_bit  = 4'($unsigned($random(seed)) % WIDTH);
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // No vld expected while idle after reset
    repeat (5) drive_cycle('0, '0);

    for (int a = 0; a < NUMADDR; a++) begin
      drive_cycle(make_write(1'b1, BITADDR'(a), fill_word(BITADDR'(a)), '1), '0);
    end

    // Full write, then read on all ports
    drive_cycle(make_write(1'b1, 10'd5, 16'hBEEF, 16'hFFFF), '0);
    drive_cycle('0, read_all(10'd5));

    // Partial write with a same cycle read of the old word
    drive_cycle(make_write(1'b1, 10'd5, 16'h1234, 16'h0FF0), read_all(10'd5));
    drive_cycle('0, read_all(10'd5));

    // Out of range requests
    drive_cycle(make_write(1'b1, BITADDR'(NUMADDR), 16'hDEAD, '1),
                read_all(BITADDR'(NUMADDR + 1)));
    drive_cycle(make_write(1'b1, 10'h3FF, 16'hF00D, '1), read_all(10'h3FF));
    for (int a = 0; a < NUMADDR; a += NUM_RD) begin
      for (int p = 0; p < NUM_RD; p++) begin
        r[p].read = 1'b1;
        r[p].adr  = BITADDR'(a + p);
      end
      drive_cycle('0, r);
    end

    for (int c = 0; c < RAND_CYCLES; c++) begin
      w = make_write(1'($random(seed)), random_addr(), 16'($random(seed)),
                     16'($random(seed)));
      for (int p = 0; p < NUM_RD; p++) begin
        r[p].read = 1'b1;
        r[p].adr  = random_addr();
      end
      drive_cycle(w, r);
    end

    while (exp_q.size() != 0) begin
      drive_cycle('0, '0);
    end
    repeat (2) drive_cycle('0, '0);
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: rtl/mem_3r1w.sv
`timescale 1ns/10ps

module mem_3r1w #(
  parameter int NUMADDR    = 1024,
  parameter int SRAM_DELAY = 1,
  parameter int FLOPIN     = 0,
  parameter int FLOPOUT    = 0
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  mem_pkg::wr_req_t                      wr,
  input  mem_pkg::rd_req_t [mem_pkg::NUM_RD-1:0] rd,
  output mem_pkg::rd_rsp_t [mem_pkg::NUM_RD-1:0] rsp
);

  import mem_pkg::*;

  wr_req_t                       sram_wr;
  rd_req_t [NUM_RD-1:0]          sram_rd;
  logic [NUM_RD-1:0][WIDTH-1:0]  sram_dout;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  mem_req_stage #(
    .NUMADDR (NUMADDR),
    .FLOPIN  (FLOPIN)
  ) u_req (
    .clk    (clk),
    .rst    (rst),
    .wr_in  (wr),
    .rd_in  (rd),
    .wr_out (sram_wr),
    .rd_out (sram_rd)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  sram_1w3r #(
    .NUMADDR    (NUMADDR),
    .SRAM_DELAY (SRAM_DELAY)
  ) u_sram (
    .clk  (clk),
    .wr   (sram_wr),
    .rd   (sram_rd),
    .dout (sram_dout)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Read strobes into the SRAM start the valid pipeline
  mem_rsp_stage #(
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPOUT    (FLOPOUT)
  ) u_rsp (
    .clk       (clk),
    .rst       (rst),
    .rd_issue  (sram_rd),
    .sram_dout (sram_dout),
    .rsp       (rsp)
  );

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int WIDTH   = 16;
  localparam int BITADDR = 10;
  localparam int NUM_RD  = 3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request and response words
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Write port, bw bit set means write that bit
  typedef struct packed {
    logic               write;
    logic [BITADDR-1:0] adr;
    logic [WIDTH-1:0]   din;
    logic [WIDTH-1:0]   bw;
  } wr_req_t;

  typedef struct packed {
    logic               read;
    logic [BITADDR-1:0] adr;
  } rd_req_t;

  // Dout is zero whenever vld is low
  typedef struct packed {
    logic             vld;
    logic [WIDTH-1:0] dout;
  } rd_rsp_t;

endpackage

// File: rtl/mem_req_stage.sv
`timescale 1ns/10ps

module mem_req_stage #(
  parameter int NUMADDR = 1024,
  parameter int FLOPIN  = 0
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  mem_pkg::wr_req_t                      wr_in,
  input  mem_pkg::rd_req_t [mem_pkg::NUM_RD-1:0] rd_in,
  output mem_pkg::wr_req_t                      wr_out,
  output mem_pkg::rd_req_t [mem_pkg::NUM_RD-1:0] rd_out
);

  import mem_pkg::*;

  wr_req_t               wr_chk;
  rd_req_t [NUM_RD-1:0]  rd_chk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Range check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Out of range requests lose their strobe, payload kept as is
  always_comb begin
    wr_chk       = wr_in;
    wr_chk.write = wr_in.write && (int'(wr_in.adr) < NUMADDR);
    for (int i = 0; i < NUM_RD; i++) begin
      rd_chk[i]      = rd_in[i];
      rd_chk[i].read = rd_in[i].read && (int'(rd_in[i].adr) < NUMADDR);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Optional input flop
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  generate
    if (FLOPIN == 1) begin : g_flop
      always_ff @(posedge clk) begin
        wr_out <= wr_chk;
        rd_out <= rd_chk;
        // Only the strobes are cleared
        if (rst) begin
          wr_out.write <= 1'b0;
          for (int i = 0; i < NUM_RD; i++) begin
            rd_out[i].read <= 1'b0;
          end
        end
      end
    end else begin : g_pass
      assign wr_out = wr_chk;
      assign rd_out = rd_chk;
    end
  endgenerate

endmodule

// File: rtl/mem_rsp_stage.sv
`timescale 1ns/10ps

module mem_rsp_stage #(
  parameter int SRAM_DELAY = 1,
  parameter int FLOPOUT    = 0
) (
  input  logic                                           clk,
  input  logic                                           rst,
  input  mem_pkg::rd_req_t [mem_pkg::NUM_RD-1:0]          rd_issue,
  input  logic [mem_pkg::NUM_RD-1:0][mem_pkg::WIDTH-1:0]  sram_dout,
  output mem_pkg::rd_rsp_t [mem_pkg::NUM_RD-1:0]          rsp
);

  import mem_pkg::*;

  logic [NUM_RD-1:0]    issue_vld;
  logic [NUM_RD-1:0]    sram_vld;
  rd_rsp_t [NUM_RD-1:0] rsp_nxt;

  always_comb begin
    for (int i = 0; i < NUM_RD; i++) begin
      issue_vld[i] = rd_issue[i].read;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Valid pipeline matching SRAM latency
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  generate
    if (SRAM_DELAY == 0) begin : g_nodly
      assign sram_vld = issue_vld;
    end else begin : g_dly
      logic [NUM_RD-1:0] vld_pipe [SRAM_DELAY];

      always_ff @(posedge clk) begin
        if (rst) begin
          for (int s = 0; s < SRAM_DELAY; s++) begin
            vld_pipe[s] <= '0;
          end
        end else begin
          vld_pipe[0] <= issue_vld;
          for (int s = 1; s < SRAM_DELAY; s++) begin
            vld_pipe[s] <= vld_pipe[s-1];
          end
        end
      end

      assign sram_vld = vld_pipe[SRAM_DELAY-1];
    end
  endgenerate

  always_comb begin
    for (int i = 0; i < NUM_RD; i++) begin
      rsp_nxt[i].vld  = sram_vld[i];
      rsp_nxt[i].dout = sram_vld[i] ? sram_dout[i] : '0;
    end
  end

  // Optional output flop
  generate
    if (FLOPOUT == 1) begin : g_flop
      always_ff @(posedge clk) begin
        rsp <= rsp_nxt;
        if (rst) begin
          for (int i = 0; i < NUM_RD; i++) begin
            rsp[i].vld <= 1'b0;
          end
        end
      end
    end else begin : g_pass
      assign rsp = rsp_nxt;
    end
  endgenerate

endmodule

// File: rtl/sram_1w3r.sv
`timescale 1ns/10ps

module sram_1w3r #(
  parameter int NUMADDR    = 1024,
  parameter int SRAM_DELAY = 1
) (
  input  logic                                            clk,
  // Port A
  input  mem_pkg::wr_req_t                                wr,
  // Ports B, C, D
  input  mem_pkg::rd_req_t [mem_pkg::NUM_RD-1:0]           rd,
  output logic [mem_pkg::NUM_RD-1:0][mem_pkg::WIDTH-1:0]   dout
);

  import mem_pkg::*;

  logic [WIDTH-1:0] mem [NUMADDR];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write port A
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Masked merge of new and stored bits
  always_ff @(posedge clk) begin
    if (wr.write) begin
      mem[wr.adr] <= (mem[wr.adr] & ~wr.bw) | (wr.din & wr.bw);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read ports B, C, D
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  generate
    for (genvar p = 0; p < NUM_RD; p++) begin : g_port
      logic [WIDTH-1:0] rd_word;

      // Array as it stands before this edge's write
      assign rd_word = mem[rd[p].adr];

      if (SRAM_DELAY == 0) begin : g_comb
        assign dout[p] = rd_word;
      end else begin : g_pipe
        logic [WIDTH-1:0] pipe [SRAM_DELAY];

        always_ff @(posedge clk) begin
          // First stage only loads on a read
          if (rd[p].read) begin
            pipe[0] <= rd_word;
          end
          for (int s = 1; s < SRAM_DELAY; s++) begin
            pipe[s] <= pipe[s-1];
          end
        end

        assign dout[p] = pipe[SRAM_DELAY-1];
      end
    end
  endgenerate

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the mem_3r1w testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_3r1w -f sim.f -o tb_mem_3r1w

./obj_dir/tb_mem_3r1w 2>&1 | tee "$LOG"

if grep -qF "All tests passed!" "$LOG"; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: sim.f
rtl/mem_pkg.sv
rtl/mem_req_stage.sv
rtl/sram_1w3r.sv
rtl/mem_rsp_stage.sv
rtl/mem_3r1w.sv
bench/mem_bit_checker.sv
bench/tb_mem_3r1w.sv
